//--- src/soric_consts.svh
`ifndef SORIC_CONSTS_SVH
`define SORIC_CONSTS_SVH

// Bus widths
`define SORIC_DATA_WIDTH       32
`define SORIC_ADDR_WIDTH       14   // Host side byte address
`define SORIC_SLAVE_ADDR_WIDTH 11   // 2 kB per slave

// SRAM banks
`define SORIC_NSRAM      2
`define SORIC_BANK_WORDS 512

// Address windows
`define SORIC_BANK_MATCH   {14'h0800, 14'h0000}   // Bank 1 in the upper slice
`define SORIC_PERIPH_MATCH 14'h2000
`define SORIC_WIN_MASK     14'h3800

// ID register value, ASCII "PRC1"
`define SORIC_PERIPH_ID 32'h50524331

`endif

//--- src/soric_bus_pkg.sv
`default_nettype none

`include "soric_consts.svh"

package soric_bus_pkg;

   // Payload types
   typedef logic [`SORIC_DATA_WIDTH-1:0]       data_t;
   typedef logic [`SORIC_DATA_WIDTH/8-1:0]     be_t;
   typedef logic [`SORIC_ADDR_WIDTH-1:0]       host_addr_t;
   typedef logic [`SORIC_SLAVE_ADDR_WIDTH-1:0] slave_addr_t;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

   // Wishbone host port FSM
   typedef enum logic [1:0] {
      HOST_IDLE     = 2'd0,
      HOST_REQ      = 2'd1,   // Request out, waiting for grant
      HOST_WAIT_RSP = 2'd2
   } host_state_e;

endpackage

`default_nettype wire

//--- src/soric_periph_pkg.sv
`default_nettype none

package soric_periph_pkg;

   // Register word index, taken from address bits 3:2
   typedef enum logic [1:0] {
      REG_ID      = 2'd0,   // Read only
      REG_SCRATCH = 2'd1
   } periph_reg_e;

   // Indices 2 and 3 read zero and ignore writes

endpackage

`default_nettype wire

//--- src/mem_bus_if.sv
`default_nettype none

`include "soric_consts.svh"

interface mem_bus_if import soric_bus_pkg::*; #(
   parameter int unsigned ADDR_W = `SORIC_ADDR_WIDTH
) ();

   // Request, held by the host until gnt
   logic              req;
   mem_op_e           op;
   logic [ADDR_W-1:0] addr;
   be_t               be;
   data_t             wdata;

   // Response
   logic              gnt;
   logic              rvalid;   // One cycle per request, writes included
   data_t             rdata;

   modport host (
      output req, op, addr, be, wdata,
      input  gnt, rvalid, rdata
   );

   modport dev (
      input  req, op, addr, be, wdata,
      output gnt, rvalid, rdata
   );

endinterface

`default_nettype wire

//--- src/wb_host_port.sv
`default_nettype none

module wb_host_port import soric_bus_pkg::*; (
   input  logic       wb_clk_i,
   input  logic       rst_n_i,
   input  logic       wbs_cyc_i,
   input  logic       wbs_stb_i,
   input  logic       wbs_we_i,
   input  be_t        wbs_sel_i,
   input  host_addr_t wbs_adr_i,
   input  data_t      wbs_dat_i,
   output logic       wbs_ack_o,
   output data_t      wbs_dat_o,
   mem_bus_if.host    bus
);

   host_state_e state_q;
   logic        ack_q;
   logic        wb_start;

   mem_op_e     op_q;
   host_addr_t  addr_q;
   be_t         be_q;
   data_t       wdata_q;
   data_t       rdata_q;

   // Strobe still high during our own ack, so skip that cycle
   assign wb_start = wbs_cyc_i & wbs_stb_i & ~ack_q;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         state_q <= HOST_IDLE;
         ack_q   <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         case (state_q)
            HOST_IDLE: begin
               if (wb_start) state_q <= HOST_REQ;
            end
            HOST_REQ: begin
               if (bus.gnt) state_q <= HOST_WAIT_RSP;   // Stalls here on back-pressure
            end
            HOST_WAIT_RSP: begin
               if (bus.rvalid) begin
                  state_q <= HOST_IDLE;
                  ack_q   <= 1'b1;
               end
            end
            default: state_q <= HOST_IDLE;
         endcase
      end
   end

   // Capture the Wishbone cycle and the read data
   always_ff @(posedge wb_clk_i) begin
      if (state_q == HOST_IDLE && wb_start) begin
         op_q    <= wbs_we_i ? MEM_WRITE : MEM_READ;
         addr_q  <= wbs_adr_i;
         be_q    <= wbs_sel_i;
         wdata_q <= wbs_dat_i;
      end
      if (state_q == HOST_WAIT_RSP && bus.rvalid) rdata_q <= bus.rdata;
   end

   assign bus.req   = (state_q == HOST_REQ);
   assign bus.op    = op_q;
   assign bus.addr  = addr_q;
   assign bus.be    = be_q;
   assign bus.wdata = wdata_q;

   assign wbs_ack_o = ack_q;
   assign wbs_dat_o = rdata_q;

endmodule

`default_nettype wire

//--- src/bus_decoder.sv
`default_nettype none

`include "soric_consts.svh"

module bus_decoder import soric_bus_pkg::*; (
   input  logic    wb_clk_i,
   input  logic    rst_n_i,
   mem_bus_if.dev  host,
   mem_bus_if.host banks [`SORIC_NSRAM],
   mem_bus_if.host periph
);

   localparam int NSRAM = `SORIC_NSRAM;
   localparam int AW    = `SORIC_ADDR_WIDTH;
   localparam int SAW   = `SORIC_SLAVE_ADDR_WIDTH;
   localparam logic [NSRAM*AW-1:0] BANK_MATCH = `SORIC_BANK_MATCH;

   host_addr_t       masked_addr;
   logic [NSRAM-1:0] bank_hit;
   logic [NSRAM-1:0] bank_gnt;
   logic [NSRAM-1:0] bank_rvalid;
   data_t            bank_rdata [NSRAM];
   logic             periph_hit;
   logic             none_hit;
   logic             accept;

   logic [NSRAM-1:0] bank_sel_q;      // Target of the outstanding request
   logic             periph_sel_q;
   logic             none_rvalid_q;   // Own response for unmapped addresses

   logic             rsp_valid;
   data_t            rsp_data;

   assign masked_addr = host.addr & `SORIC_WIN_MASK;

   for (genvar i = 0; i < NSRAM; i++) begin : gen_bank
      assign bank_hit[i]    = (masked_addr == BANK_MATCH[i*AW +: AW]);
      assign banks[i].req   = host.req & bank_hit[i];
      assign banks[i].op    = host.op;
      assign banks[i].addr  = host.addr[SAW-1:0];
      assign banks[i].be    = host.be;
      assign banks[i].wdata = host.wdata;
      assign bank_gnt[i]    = banks[i].gnt;
      assign bank_rvalid[i] = banks[i].rvalid;
      assign bank_rdata[i]  = banks[i].rdata;
   end

   assign periph_hit   = (masked_addr == `SORIC_PERIPH_MATCH);
   assign none_hit     = ~(|bank_hit) & ~periph_hit;

   assign periph.req   = host.req & periph_hit;
   assign periph.op    = host.op;
   assign periph.addr  = host.addr[SAW-1:0];
   assign periph.be    = host.be;
   assign periph.wdata = host.wdata;

   // Unmapped requests are granted at once
   assign host.gnt = (|(bank_hit & bank_gnt)) | (periph_hit & periph.gnt) | (none_hit & host.req);
   assign accept   = host.req & host.gnt;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         bank_sel_q    <= '0;
         periph_sel_q  <= 1'b0;
         none_rvalid_q <= 1'b0;
      end else if (accept) begin
         bank_sel_q    <= bank_hit;
         periph_sel_q  <= periph_hit;
         none_rvalid_q <= none_hit;
      end else begin
         none_rvalid_q <= 1'b0;
      end
   end

   // Response steering, zero data when nothing is selected
   always_comb begin
      rsp_valid = none_rvalid_q | (periph_sel_q & periph.rvalid);
      rsp_data  = '0;
      if (periph_sel_q) rsp_data = periph.rdata;
      for (int i = 0; i < NSRAM; i++) begin
         rsp_valid = rsp_valid | (bank_sel_q[i] & bank_rvalid[i]);
         if (bank_sel_q[i]) rsp_data = bank_rdata[i];
      end
   end

   assign host.rvalid = rsp_valid;
   assign host.rdata  = rsp_data;

endmodule

`default_nettype wire

//--- src/sram_bank.sv
`default_nettype none

`include "soric_consts.svh"

module sram_bank import soric_bus_pkg::*; (
   input  logic   wb_clk_i,
   mem_bus_if.dev bus
);

   localparam int WORD_AW = $clog2(`SORIC_BANK_WORDS);

   data_t              mem_q [`SORIC_BANK_WORDS];
   logic [WORD_AW-1:0] word_idx;
   logic               rvalid_q;
   data_t              rdata_q;

   assign word_idx = bus.addr[`SORIC_SLAVE_ADDR_WIDTH-1:2];
   assign bus.gnt  = 1'b1;   // Never stalls

   // Byte masked write
   always_ff @(posedge wb_clk_i) begin
      if (bus.req && bus.op == MEM_WRITE) begin
         for (int b = 0; b < $bits(be_t); b++) begin
            if (bus.be[b]) mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
         end
      end
   end

   // Response one cycle after the request
   always_ff @(posedge wb_clk_i) begin
      rvalid_q <= bus.req;
      if (bus.req) rdata_q <= mem_q[word_idx];   // Old word on writes
   end

   assign bus.rvalid = rvalid_q;
   assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- src/periph_regs.sv
`default_nettype none

`include "soric_consts.svh"

module periph_regs import soric_bus_pkg::*, soric_periph_pkg::*; (
   input  logic   wb_clk_i,
   input  logic   rst_n_i,
   mem_bus_if.dev bus
);

   logic        gnt_q;      // High in the second cycle of a request
   logic        rvalid_q;
   data_t       rdata_q;
   data_t       scratch_q;
   periph_reg_e reg_idx;
   data_t       rd_mux;
   logic        accept;

   assign reg_idx = periph_reg_e'(bus.addr[3:2]);
   assign accept  = bus.req & gnt_q;

   always_comb begin
      case (reg_idx)
         REG_ID:      rd_mux = `SORIC_PERIPH_ID;
         REG_SCRATCH: rd_mux = scratch_q;
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         gnt_q     <= 1'b0;
         rvalid_q  <= 1'b0;
         scratch_q <= '0;
      end else begin
         gnt_q    <= bus.req & ~gnt_q;   // One wait state
         rvalid_q <= accept;
         if (accept && bus.op == MEM_WRITE && reg_idx == REG_SCRATCH) begin
            for (int b = 0; b < $bits(be_t); b++) begin
               if (bus.be[b]) scratch_q[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (accept) rdata_q <= rd_mux;
   end

   assign bus.gnt    = gnt_q;
   assign bus.rvalid = rvalid_q;
   assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- src/soric_mem_top.sv
`default_nettype none

`include "soric_consts.svh"

module soric_mem_top import soric_bus_pkg::*; (
   input  logic       wb_clk_i,
   input  logic       rst_n_i,
   input  logic       wbs_cyc_i,
   input  logic       wbs_stb_i,
   input  logic       wbs_we_i,
   input  be_t        wbs_sel_i,
   input  host_addr_t wbs_adr_i,
   input  data_t      wbs_dat_i,
   output logic       wbs_ack_o,
   output data_t      wbs_dat_o
);

   // Host side bus and one bus per slave
   mem_bus_if #(.ADDR_W(`SORIC_ADDR_WIDTH))       host_bus ();
   mem_bus_if #(.ADDR_W(`SORIC_SLAVE_ADDR_WIDTH)) bank_bus [`SORIC_NSRAM] ();
   mem_bus_if #(.ADDR_W(`SORIC_SLAVE_ADDR_WIDTH)) periph_bus ();

   wb_host_port host_port_i (
      .wb_clk_i  (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .wbs_cyc_i (wbs_cyc_i),
      .wbs_stb_i (wbs_stb_i),
      .wbs_we_i  (wbs_we_i),
      .wbs_sel_i (wbs_sel_i),
      .wbs_adr_i (wbs_adr_i),
      .wbs_dat_i (wbs_dat_i),
      .wbs_ack_o (wbs_ack_o),
      .wbs_dat_o (wbs_dat_o),
      .bus       (host_bus)
   );

   bus_decoder decoder_i (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .host     (host_bus),
      .banks    (bank_bus),
      .periph   (periph_bus)
   );

   for (genvar i = 0; i < `SORIC_NSRAM; i++) begin : gen_sram
      sram_bank sram_i (
         .wb_clk_i (wb_clk_i),
         .bus      (bank_bus[i])
      );
   end

   periph_regs periph_i (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .bus      (periph_bus)
   );

endmodule

`default_nettype wire

//--- tb/soric_asserts.sv
`default_nettype none

module soric_asserts import soric_bus_pkg::*; (
   input logic       wb_clk_i,
   input logic       rst_n_i,
   input logic       wbs_cyc_i,
   input logic       wbs_stb_i,
   input logic       wbs_ack_i,
   input logic       req_i,
   input logic       gnt_i,
   input logic       rvalid_i,
   input mem_op_e    op_i,
   input host_addr_t addr_i,
   input be_t        be_i,
   input data_t      wdata_i
);

   int unsigned fail_cnt = 0;   // Failed assertions so far

   ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      wbs_ack_i |=> !wbs_ack_i)
      else begin
         $error("Wishbone ack held for more than one cycle");
         fail_cnt++;
      end

   ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      wbs_ack_i |-> (wbs_cyc_i && wbs_stb_i))
      else begin
         $error("Wishbone ack without cyc and stb");
         fail_cnt++;
      end

   // Every device answers exactly one cycle after the grant
   rvalid_after_gnt: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      rvalid_i |-> $past(req_i && gnt_i))
      else begin
         $error("Host bus rvalid without a grant");
         fail_cnt++;
      end

   req_stable: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      (req_i && !gnt_i) |=> (req_i && $stable({op_i, addr_i, be_i, wdata_i})))
      else begin
         $error("Host bus request changed before grant");
         fail_cnt++;
      end

endmodule

bind soric_mem_top soric_asserts asserts_i (
   .wb_clk_i  (wb_clk_i),
   .rst_n_i   (rst_n_i),
   .wbs_cyc_i (wbs_cyc_i),
   .wbs_stb_i (wbs_stb_i),
   .wbs_ack_i (wbs_ack_o),
   .req_i     (host_bus.req),
   .gnt_i     (host_bus.gnt),
   .rvalid_i  (host_bus.rvalid),
   .op_i      (host_bus.op),
   .addr_i    (host_bus.addr),
   .be_i      (host_bus.be),
   .wdata_i   (host_bus.wdata)
);

`default_nettype wire

//--- tb/tb_soric_top.sv
`default_nettype none

`include "soric_consts.svh"

module tb_clkgen #(
   parameter int PERIOD = 40
) (
   output logic clk_o
);
   initial clk_o = 1'b0;
   always #(PERIOD / 2) clk_o = ~clk_o;
endmodule

module tb_soric_top import soric_bus_pkg::*, soric_periph_pkg::*; ();

   localparam int NRAND = 64;   // Random accesses after the file vectors

   logic       wb_clk;
   logic       rst_n;
   logic       wbs_cyc;
   logic       wbs_stb;
   logic       wbs_we;
   be_t        wbs_sel;
   host_addr_t wbs_adr;
   data_t      wbs_dat_w;
   logic       wbs_ack;
   data_t      wbs_dat_r;

   logic       vec_we [$];
   host_addr_t vec_adr [$];
   be_t        vec_sel [$];
   data_t      vec_wdat [$];
   data_t      vec_exp [$];

   data_t      shadow [32];        // Words 0x100..0x13c of each bank
   logic       shadow_init [32];
   int         seed = 32'h362292c5;
   int         cycle_cnt = 0;
   int         timeout_limit = 0;
   int         ack_cnt = 0;
   int         access_cnt = 0;

   tb_clkgen #(.PERIOD(40)) clkgen_i (.clk_o(wb_clk));

   soric_mem_top i_dut (
      .wb_clk_i  (wb_clk),
      .rst_n_i   (rst_n),
      .wbs_cyc_i (wbs_cyc),
      .wbs_stb_i (wbs_stb),
      .wbs_we_i  (wbs_we),
      .wbs_sel_i (wbs_sel),
      .wbs_adr_i (wbs_adr),
      .wbs_dat_i (wbs_dat_w),
      .wbs_ack_o (wbs_ack),
      .wbs_dat_o (wbs_dat_r)
   );

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("Error: %s is %h, expected %h", name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_ack_count(input int got, input int exp);
      if (got != exp) begin
         $display("Error: wbs_ack_o count is %h, expected %h", got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // Byte enable rule of banks and scratch
   function automatic data_t merge_bytes(input data_t old, input data_t wdat, input be_t sel);
      data_t res;
      res = old;
      for (int b = 0; b < $bits(be_t); b++) begin
         if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];
      end
      return res;
   endfunction

   task automatic read_stimulus();
      int         fd;
      string      line;
      logic       we;
      host_addr_t adr;
      be_t        sel;
      data_t      wdat;
      data_t      exp;
      fd = $fopen("tb/soric_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tb/soric_stimulus.txt");
         $display("TEST FAILED");
         $fatal(1, "No stimulus");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               if ($sscanf(line, "%h %h %h %h %h", we, adr, sel, wdat, exp) == 5) begin
                  vec_we.push_back(we);
                  vec_adr.push_back(adr);
                  vec_sel.push_back(sel);
                  vec_wdat.push_back(wdat);
                  vec_exp.push_back(exp);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // One Wishbone classic access, inputs change on the falling edge
   task automatic wb_access(input logic we, input host_addr_t adr, input be_t sel,
                            input data_t wdat, output data_t rdat);
      @(negedge wb_clk);
      wbs_cyc   = 1'b1;
      wbs_stb   = 1'b1;
      wbs_we    = we;
      wbs_sel   = sel;
      wbs_adr   = adr;
      wbs_dat_w = wdat;
      do @(negedge wb_clk); while (!wbs_ack);
      rdat = wbs_dat_r;
      @(negedge wb_clk);   // Ack taken at the rising edge in between
      wbs_cyc = 1'b0;
      wbs_stb = 1'b0;
      wbs_we  = 1'b0;
      access_cnt++;
   endtask

   always @(posedge wb_clk) begin
      cycle_cnt++;
      if (rst_n && wbs_ack) ack_cnt++;
      if (i_dut.asserts_i.fail_cnt != 0) begin
         $display("An assertion on the Wishbone or host bus failed");
         $display("TEST FAILED");
         $fatal(1, "Assertion failure");
      end else if (timeout_limit != 0 && cycle_cnt > timeout_limit) begin
         $display("Timeout after %0d cycles while waiting for an ack", cycle_cnt);
         $display("TEST FAILED");
         $fatal(1, "Timeout");
      end
   end

   initial begin
      data_t      rdat;
      data_t      r;
      logic [4:0] idx;
      logic       we;
      be_t        sel;
      host_addr_t adr;
      data_t      wdat;
      rst_n     = 1'b0;
      wbs_cyc   = 1'b0;
      wbs_stb   = 1'b0;
      wbs_we    = 1'b0;
      wbs_sel   = '0;
      wbs_adr   = '0;
      wbs_dat_w = '0;
      foreach (shadow_init[i]) shadow_init[i] = 1'b0;
      read_stimulus();
      if (vec_we.size() == 0) begin
         $display("The stimulus file holds no vectors");
         $display("TEST FAILED");
         $fatal(1, "No stimulus");
      end
      timeout_limit = (vec_we.size() + 1 + NRAND) * 8 + 20;
      repeat (3) @(negedge wb_clk);
      rst_n = 1'b1;

      for (int i = 0; i < vec_we.size(); i++) begin
         wb_access(vec_we[i], vec_adr[i], vec_sel[i], vec_wdat[i], rdat);
         if (!vec_we[i]) check_data($sformatf("wbs_dat_o at %h", vec_adr[i]), rdat, vec_exp[i]);
      end

      // ID register addressed through the register map
      adr = host_addr_t'(`SORIC_PERIPH_MATCH) | (host_addr_t'(REG_ID) << 2);
      wb_access(1'b0, adr, 4'hf, '0, rdat);
      check_data("wbs_dat_o of REG_ID", rdat, `SORIC_PERIPH_ID);

      // Random traffic, a word is fully written before any partial write or read
      for (int k = 0; k < NRAND; k++) begin
         r    = $random(seed);
         wdat = $random(seed);
         idx  = r[4:0];
         adr  = host_addr_t'(r[4] ? 14'h0900 : 14'h0100) | host_addr_t'({r[3:0], 2'b00});
         we   = r[8] | ~shadow_init[idx];
         sel  = shadow_init[idx] ? r[12:9] : 4'hf;
         wb_access(we, adr, sel, wdat, rdat);
         if (we) begin
            shadow[idx]      = merge_bytes(shadow[idx], wdat, sel);
            shadow_init[idx] = 1'b1;
         end else begin
            check_data($sformatf("wbs_dat_o at %h", adr), rdat, shadow[idx]);
         end
      end

      check_ack_count(ack_cnt, access_cnt);
      if (i_dut.asserts_i.fail_cnt == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("%0d assertion failures", i_dut.asserts_i.fail_cnt);
         $display("TEST FAILED");
         $fatal(1, "Assertion failures");
      end
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/soric_bus_pkg.sv
src/soric_periph_pkg.sv
src/mem_bus_if.sv
src/wb_host_port.sv
src/bus_decoder.sv
src/sram_bank.sv
src/periph_regs.sv
src/soric_mem_top.sv
tb/soric_asserts.sv
tb/tb_soric_top.sv

//--- Bender.yml
package:
  name: soric_mem

sources:
  - include_dirs:
      - src
    files:
      - src/soric_bus_pkg.sv
      - src/soric_periph_pkg.sv
      - src/mem_bus_if.sv
      - src/wb_host_port.sv
      - src/bus_decoder.sv
      - src/sram_bank.sv
      - src/periph_regs.sv
      - src/soric_mem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/soric_asserts.sv
      - tb/tb_soric_top.sv

//--- tb/soric_stimulus.txt
# op addr sel wdata expected, all hex; op 1 is a write
# expected read data is ignored for writes
0 2000 f 00000000 50524331
0 2004 f 00000000 00000000
0 1000 f 00000000 00000000
1 0010 f deadbeef 00000000
1 0810 f cafef00d 00000000
0 0010 f 00000000 deadbeef
0 0810 f 00000000 cafef00d
1 0010 3 11223344 00000000
0 0010 f 00000000 dead3344
1 0810 c 55667788 00000000
0 0810 f 00000000 5566f00d
1 2004 f 12345678 00000000
1 2004 2 0000ab00 00000000
0 2004 f 00000000 1234ab78
1 2000 f ffffffff 00000000
0 2000 f 00000000 50524331
1 1000 f a5a5a5a5 00000000
0 1000 f 00000000 00000000
0 0010 f 00000000 dead3344
0 2008 f 00000000 00000000
